/* hdl/mlsePkg.sv */
package mlsePkg;

    // trellis and block sizes
    localparam int NumStates = 16;
    localparam int NumStages = 4;

    localparam int SampleWidth = 18;
    localparam int MetricWidth = 18;

    localparam int StateBits = $clog2(NumStates);
    localparam int StageBits = $clog2(NumStages);

    // one setup point per state per stage.
    localparam int SetupPoints = NumStages * NumStates;
    localparam int SetupCountBits = StageBits + StateBits;

    localparam logic [MetricWidth-1:0] MetricMax = '1; // saturation limit of every sum.

    localparam int AcsLatency = 2; // metric in to updated metric out.

    typedef struct packed {
        logic signed [SampleWidth-1:0] re;
        logic signed [SampleWidth-1:0] im;
    } complexSample;

    typedef logic [StateBits-1:0] stateIndex;

    typedef logic [MetricWidth-1:0] metric;

    // Setup progress of a frame.
    typedef enum logic [1:0] {
        setupIdle,
        setupLoading,
        setupDone
    } setupState;

endpackage

/* hdl/acsOp.sv */
`timescale 1ns/1ps

module acsOp (
    input  logic                  clk,
    input  logic                  reset,
    input  mlsePkg::complexSample refPoint,
    input  mlsePkg::complexSample sample,
    input  logic                  accMetricInEn,
    input  mlsePkg::metric        accMetricIn,
    input  logic                  streamStart,
    output logic                  accMetricOutEn,
    output mlsePkg::metric        accMetricOut,
    output mlsePkg::metric        minMetric,
    output mlsePkg::stateIndex    minState
);

    logic signed [mlsePkg::SampleWidth:0] diffRe;
    logic signed [mlsePkg::SampleWidth:0] diffIm;
    logic signed [mlsePkg::SampleWidth:0] magRe;
    logic signed [mlsePkg::SampleWidth:0] magIm;
    mlsePkg::metric absRe;
    mlsePkg::metric absIm;
    mlsePkg::metric metricDly;
    logic [mlsePkg::MetricWidth+1:0] fullSum;
    mlsePkg::metric sumSat;
    logic [mlsePkg::AcsLatency-1:0] enPipe;
    mlsePkg::stateIndex outIdx;

    always_comb begin
        diffRe = {refPoint.re[mlsePkg::SampleWidth-1], refPoint.re}
               - {sample.re[mlsePkg::SampleWidth-1], sample.re};
        diffIm = {refPoint.im[mlsePkg::SampleWidth-1], refPoint.im}
               - {sample.im[mlsePkg::SampleWidth-1], sample.im};
        magRe = diffRe[mlsePkg::SampleWidth] ? -diffRe : diffRe; // magnitude fits 18 bits.
        magIm = diffIm[mlsePkg::SampleWidth] ? -diffIm : diffIm;
        fullSum = {2'b00, absRe} + {2'b00, absIm} + {2'b00, metricDly};
        // all terms are non-negative, so one clamp equals clamping each addition.
        sumSat = (fullSum > {2'b00, mlsePkg::MetricMax}) ? mlsePkg::MetricMax
                                                          : fullSum[mlsePkg::MetricWidth-1:0];
    end

    always_ff @(posedge clk) begin
        absRe <= magRe[mlsePkg::MetricWidth-1:0];
        absIm <= magIm[mlsePkg::MetricWidth-1:0];
        metricDly <= accMetricIn;
        accMetricOut <= sumSat;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            enPipe <= '0;
        end else begin
            enPipe <= {enPipe[mlsePkg::AcsLatency-2:0], accMetricInEn};
        end
    end

    assign accMetricOutEn = enPipe[mlsePkg::AcsLatency-1];

    always_ff @(posedge clk) begin
        if (reset || streamStart) begin
            minMetric <= mlsePkg::MetricMax;
            minState <= '0; // a stream of all MetricMax keeps state 0.
            outIdx <= '0;
        end else if (enPipe[mlsePkg::AcsLatency-2]) begin
            if (sumSat < minMetric) begin
                minMetric <= sumSat;
                minState <= outIdx;
            end
            outIdx <= outIdx + 1'b1;
        end
    end

endmodule

/* hdl/acsStage.sv */
`timescale 1ns/1ps

module acsStage (
    input  logic                  clk,
    input  logic                  clkEn,
    input  logic                  reset,
    input  logic                  startFrame,
    input  logic                  startBlock,
    input  mlsePkg::complexSample blockSample,
    input  logic                  loadEn,
    input  mlsePkg::complexSample setupPoint,
    input  mlsePkg::metric        accMetricIn,
    output logic                  metricRequest,
    output logic                  metricOutEn,
    output mlsePkg::metric        accMetricOut,
    output logic                  startNextStage
);

    mlsePkg::complexSample refTable [mlsePkg::NumStates];
    mlsePkg::stateIndex wrAddr;
    mlsePkg::stateIndex stateCnt;
    mlsePkg::complexSample stageSample;
    logic startStage;

    always_ff @(posedge clk) begin
        if (reset || (clkEn && startFrame)) begin
            wrAddr <= '0;
        end else if (loadEn) begin
            wrAddr <= wrAddr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (loadEn) begin
            refTable[wrAddr] <= setupPoint;
        end
    end

    always_ff @(posedge clk) begin
        if (clkEn && startBlock) begin
            stageSample <= blockSample; // held for the whole stream.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            startStage <= 1'b0;
            startNextStage <= 1'b0;
            metricRequest <= 1'b0;
            stateCnt <= '0;
        end else begin
            startStage <= clkEn && startBlock;
            // the next stage then requests AcsLatency cycles after this one.
            startNextStage <= startStage;
            if (startStage) begin
                metricRequest <= 1'b1;
                stateCnt <= '0;
            end else if (metricRequest) begin
                stateCnt <= stateCnt + 1'b1;
                if (stateCnt == mlsePkg::stateIndex'(mlsePkg::NumStates - 1)) begin
                    metricRequest <= 1'b0;
                end
            end
        end
    end

    acsOp acs (
        .clk            (clk),
        .reset          (reset),
        .refPoint       (refTable[stateCnt]),
        .sample         (stageSample),
        .accMetricInEn  (metricRequest),
        .accMetricIn    (accMetricIn),
        .streamStart    (startStage),
        .accMetricOutEn (metricOutEn),
        .accMetricOut   (accMetricOut),
        .minMetric      (),
        .minState       ()
    );

endmodule

/* hdl/setupDistributor.sv */
`timescale 1ns/1ps

module setupDistributor (
    input  logic                           clk,
    input  logic                           clkEn,
    input  logic                           reset,
    input  logic                           startFrame,
    input  logic                           setupValid,
    input  mlsePkg::complexSample          setupPoint,
    input  logic                           startBlock,
    output logic [mlsePkg::NumStages-1:0]  loadEn,
    output logic                           setupComplete,
    output logic                           firstStageStart
);

    mlsePkg::setupState state;
    logic [mlsePkg::SetupCountBits-1:0] pointCnt;
    logic [mlsePkg::StageBits-1:0] stageSel;
    logic frameStart;
    logic pointTaken;

    assign frameStart = clkEn && startFrame;

    // points in the frame start cycle are dropped, since the stage tables rewind then.
    assign pointTaken = setupValid && !frameStart && (state != mlsePkg::setupDone);

    assign stageSel = pointCnt[mlsePkg::SetupCountBits-1:mlsePkg::StateBits];

    always_comb begin
        loadEn = '0;
        if (pointTaken) begin
            loadEn[stageSel] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || frameStart) begin
            state <= mlsePkg::setupIdle;
            pointCnt <= '0;
        end else if (pointTaken) begin
            pointCnt <= pointCnt + 1'b1;
            if (pointCnt == mlsePkg::SetupCountBits'(mlsePkg::SetupPoints - 1)) begin
                state <= mlsePkg::setupDone;
            end else begin
                state <= mlsePkg::setupLoading;
            end
        end
    end

    assign setupComplete = (state == mlsePkg::setupDone);

    // blocks before the tables are full never reach the chain.
    assign firstStageStart = clkEn && startBlock && setupComplete;

endmodule

/* hdl/metricDecision.sv */
`timescale 1ns/1ps

module metricDecision (
    input  logic               clk,
    input  logic               reset,
    input  logic               startFrame,
    input  logic               metricRequest,
    input  logic               metricOutEn,
    input  mlsePkg::metric     accMetricIn,
    output mlsePkg::metric     metricSupply,
    output logic               decisionValid,
    output mlsePkg::stateIndex bestState,
    output mlsePkg::metric     bestMetric
);

    mlsePkg::metric store [mlsePkg::NumStates];
    mlsePkg::stateIndex reqIdx;
    mlsePkg::stateIndex wrIdx;
    mlsePkg::metric runMin;
    mlsePkg::stateIndex runState;
    mlsePkg::metric candMin;
    mlsePkg::stateIndex candState;
    logic lastState;
    logic fresh;

    assign lastState = (wrIdx == mlsePkg::stateIndex'(mlsePkg::NumStates - 1));

    always_comb begin
        candMin = runMin;
        candState = runState;
        // strict compare keeps the lowest index on ties.
        if ((wrIdx == '0) || (accMetricIn < runMin)) begin
            candMin = accMetricIn;
            candState = wrIdx;
        end
    end

    // entry k is read by stage 0 before the last stage overwrites it.
    assign metricSupply = fresh ? '0 : store[reqIdx] - bestMetric;

    always_ff @(posedge clk) begin
        if (metricOutEn) begin
            store[wrIdx] <= accMetricIn;
            runMin <= candMin;
            runState <= candState;
            if (lastState) begin
                bestMetric <= candMin;
                bestState <= candState;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            reqIdx <= '0;
            wrIdx <= '0;
            fresh <= 1'b1;
            decisionValid <= 1'b0;
        end else begin
            decisionValid <= 1'b0;
            if (startFrame) begin
                reqIdx <= '0;
                wrIdx <= '0;
                fresh <= 1'b1; // a new frame starts from zero metrics.
            end else begin
                if (metricRequest) begin
                    reqIdx <= reqIdx + 1'b1;
                end
                if (metricOutEn) begin
                    wrIdx <= wrIdx + 1'b1;
                    if (lastState) begin
                        decisionValid <= 1'b1;
                        fresh <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

/* hdl/mlseDetector.sv */
`timescale 1ns/1ps

module mlseDetector (
    input  logic                                          clk,
    input  logic                                          clkEn,
    input  logic                                          reset,
    input  logic                                          startFrame,
    input  logic                                          setupValid,
    input  mlsePkg::complexSample                         setupPoint,
    input  logic                                          startBlock,
    input  mlsePkg::complexSample [mlsePkg::NumStages-1:0] blockSamples,
    output logic                                          setupComplete,
    output logic                                          decisionValid,
    output mlsePkg::stateIndex                            bestState,
    output mlsePkg::metric                                bestMetric
);

    logic [mlsePkg::NumStages-1:0] loadEn;
    logic [mlsePkg::NumStages:0] stageStart;
    logic [mlsePkg::NumStages-1:0] metricRequest;
    logic [mlsePkg::NumStages-1:0] metricOutEn;
    mlsePkg::metric stageMetric [mlsePkg::NumStages+1]; // entry 0 is the decision unit supply.
    logic frameStart;

    assign frameStart = clkEn && startFrame;

    setupDistributor distributor (
        .clk             (clk),
        .clkEn           (clkEn),
        .reset           (reset),
        .startFrame      (startFrame),
        .setupValid      (setupValid),
        .setupPoint      (setupPoint),
        .startBlock      (startBlock),
        .loadEn          (loadEn),
        .setupComplete   (setupComplete),
        .firstStageStart (stageStart[0])
    );

    for (genvar s = 0; s < mlsePkg::NumStages; s++) begin : genStage
        acsStage stage (
            .clk            (clk),
            .clkEn          (clkEn),
            .reset          (reset),
            .startFrame     (startFrame),
            .startBlock     (stageStart[s]),
            .blockSample    (blockSamples[s]),
            .loadEn         (loadEn[s]),
            .setupPoint     (setupPoint),
            .accMetricIn    (stageMetric[s]),
            .metricRequest  (metricRequest[s]),
            .metricOutEn    (metricOutEn[s]),
            .accMetricOut   (stageMetric[s+1]),
            .startNextStage (stageStart[s+1])
        );
    end

    metricDecision decision (
        .clk           (clk),
        .reset         (reset),
        .startFrame    (frameStart),
        .metricRequest (metricRequest[0]),
        .metricOutEn   (metricOutEn[mlsePkg::NumStages-1]),
        .accMetricIn   (stageMetric[mlsePkg::NumStages]),
        .metricSupply  (stageMetric[0]),
        .decisionValid (decisionValid),
        .bestState     (bestState),
        .bestMetric    (bestMetric)
    );

endmodule

/* tb/mlseModel.svh */
`ifndef MLSE_MODEL_SVH
`define MLSE_MODEL_SVH

mlsePkg::complexSample modelRef [mlsePkg::NumStages][mlsePkg::NumStates];
mlsePkg::metric modelAcc [mlsePkg::NumStates];
mlsePkg::metric modelMin = '0;
logic modelFresh = 1'b1;

function automatic mlsePkg::metric satAdd(input mlsePkg::metric a, input mlsePkg::metric b);
    longint sum;
    sum = longint'(a) + longint'(b);
    return (sum > longint'(mlsePkg::MetricMax)) ? mlsePkg::MetricMax : mlsePkg::metric'(sum);
endfunction

function automatic mlsePkg::metric absDiff(input logic signed [mlsePkg::SampleWidth-1:0] a,
                                           input logic signed [mlsePkg::SampleWidth-1:0] b);
    int d;
    d = int'(a) - int'(b);
    if (d < 0) begin
        d = -d;
    end
    return mlsePkg::metric'(d); // at most 2^18 - 1, so it always fits.
endfunction

function automatic mlsePkg::metric branchMetric(input mlsePkg::complexSample refPt,
                                                input mlsePkg::complexSample smp);
    return satAdd(absDiff(refPt.re, smp.re), absDiff(refPt.im, smp.im));
endfunction

task automatic startModelFrame();
    modelFresh = 1'b1;
endtask

task automatic storeReference(input int index, input mlsePkg::complexSample point);
    modelRef[index / mlsePkg::NumStates][index % mlsePkg::NumStates] = point;
endtask

// each state keeps its own metric, offset by the previous block's minimum.
task automatic predictBlock(input mlsePkg::complexSample [mlsePkg::NumStages-1:0] samples,
                            output mlsePkg::stateIndex expState,
                            output mlsePkg::metric expMetric);
    mlsePkg::metric m;
    for (int k = 0; k < mlsePkg::NumStates; k++) begin
        m = modelFresh ? '0 : modelAcc[k] - modelMin;
        for (int s = 0; s < mlsePkg::NumStages; s++) begin
            m = satAdd(m, branchMetric(modelRef[s][k], samples[s]));
        end
        modelAcc[k] = m;
    end
    expState = '0;
    expMetric = modelAcc[0];
    for (int k = 1; k < mlsePkg::NumStates; k++) begin
        if (modelAcc[k] < expMetric) begin // ties stay with the lower index.
            expMetric = modelAcc[k];
            expState = mlsePkg::stateIndex'(k);
        end
    end
    modelMin = expMetric;
    modelFresh = 1'b0;
endtask

`endif

/* tb/mlseDetectorTb.sv */
`timescale 1ns/1ps

module mlseDetectorTb;

    localparam int DecisionLatency = 18 + 2 * mlsePkg::NumStages;
    localparam int DecisionWait = 60;
    localparam int NumBlocks = 10;
    localparam int SetupCycles = 2 * (mlsePkg::SetupPoints + 8);
    localparam int WatchdogCycles = NumBlocks * 32 + SetupCycles + 200;

    logic clk;
    logic clkEn;
    logic reset;
    logic startFrame;
    logic setupValid;
    mlsePkg::complexSample setupPoint;
    logic startBlock;
    mlsePkg::complexSample [mlsePkg::NumStages-1:0] blockSamples;
    logic setupComplete;
    logic decisionValid;
    mlsePkg::stateIndex bestState;
    mlsePkg::metric bestMetric;

    logic [31:0] rngState = 32'h0bc49335;
    int cycle = 0;
    int checks = 0;
    int errors = 0;

    `include "mlseModel.svh"

    mlseDetector UUT (
        .clk           (clk),
        .clkEn         (clkEn),
        .reset         (reset),
        .startFrame    (startFrame),
        .setupValid    (setupValid),
        .setupPoint    (setupPoint),
        .startBlock    (startBlock),
        .blockSamples  (blockSamples),
        .setupComplete (setupComplete),
        .decisionValid (decisionValid),
        .bestState     (bestState),
        .bestMetric    (bestMetric)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1; // read only at falling edges.

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("watchdog expired after %0d cycles without reaching the end", WatchdogCycles);
        $display("Test failed");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // 12-bit parts keep ordinary blocks clear of saturation.
    function automatic mlsePkg::complexSample randomPoint();
        mlsePkg::complexSample p;
        rngState = xorshift(rngState);
        p.re = {{6{rngState[11]}}, rngState[11:0]};
        p.im = {{6{rngState[27]}}, rngState[27:16]};
        return p;
    endfunction

    task automatic compareHex(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checks++;
        assert (got == expected) else begin
            errors++;
            $display("FAIL %s got 0x%0h expected 0x%0h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic checkPhase(input mlsePkg::setupState expected);
        compareHex("distributor state", 32'(UUT.distributor.state), 32'(expected));
    endtask

    task automatic loadFrame();
        mlsePkg::complexSample point;
        @(posedge clk);
        startFrame <= 1'b1;
        @(posedge clk);
        startFrame <= 1'b0;
        @(negedge clk);
        compareHex("setupComplete", 32'(setupComplete), 32'd0);
        checkPhase(mlsePkg::setupIdle);
        startModelFrame();
        for (int i = 0; i < mlsePkg::SetupPoints; i++) begin
            point = randomPoint();
            storeReference(i, point);
            @(posedge clk);
            setupValid <= 1'b1;
            setupPoint <= point;
            @(negedge clk);
            compareHex("setupComplete", 32'(setupComplete), 32'd0);
            if (i == 0) begin
                checkPhase(mlsePkg::setupIdle);
            end else begin
                checkPhase(mlsePkg::setupLoading);
            end
        end
        @(posedge clk);
        setupValid <= 1'b0;
        @(negedge clk);
        compareHex("setupComplete", 32'(setupComplete), 32'd1);
        checkPhase(mlsePkg::setupDone);
    endtask

    task automatic issueIgnoredBlock();
        @(posedge clk);
        for (int s = 0; s < mlsePkg::NumStages; s++) begin
            blockSamples[s] <= randomPoint();
        end
        startBlock <= 1'b1;
        @(posedge clk);
        startBlock <= 1'b0;
        repeat (30) begin
            @(negedge clk);
            compareHex("decisionValid", 32'(decisionValid), 32'd0);
        end
    endtask

    task automatic runBlock(input logic extreme);
        mlsePkg::complexSample [mlsePkg::NumStages-1:0] samples;
        mlsePkg::complexSample corner;
        mlsePkg::stateIndex expState;
        mlsePkg::metric expMetric;
        int issueCycle;
        int waited;
        corner.re = {1'b1, {(mlsePkg::SampleWidth-1){1'b0}}}; // most negative value.
        corner.im = {1'b1, {(mlsePkg::SampleWidth-1){1'b0}}};
        for (int s = 0; s < mlsePkg::NumStages; s++) begin
            samples[s] = extreme ? corner : randomPoint();
        end
        predictBlock(samples, expState, expMetric);
        @(posedge clk);
        blockSamples <= samples; // held until the next block while each stage latches its own.
        startBlock <= 1'b1;
        @(negedge clk);
        issueCycle = cycle;
        @(posedge clk);
        startBlock <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!decisionValid && waited < DecisionWait) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        assert (decisionValid) else begin
            errors++;
            $display("decisionValid did not arrive within %0d cycles of startBlock", DecisionWait);
        end
        if (decisionValid) begin
            compareHex("decision latency", 32'(cycle - issueCycle), 32'(DecisionLatency));
            compareHex("bestState", 32'(bestState), 32'(expState));
            compareHex("bestMetric", 32'(bestMetric), 32'(expMetric));
        end
        repeat (4) @(posedge clk);
    endtask

    initial begin
        clkEn = 1'b1;
        reset = 1'b1;
        startFrame = 1'b0;
        setupValid = 1'b0;
        setupPoint = '0;
        startBlock = 1'b0;
        blockSamples = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        compareHex("setupComplete", 32'(setupComplete), 32'd0);
        compareHex("decisionValid", 32'(decisionValid), 32'd0);
        issueIgnoredBlock();
        loadFrame();
        repeat (5) runBlock(1'b0);
        runBlock(1'b1);
        compareHex("bestMetric", 32'(bestMetric), 32'(mlsePkg::MetricMax));
        runBlock(1'b0);
        loadFrame();
        repeat (2) runBlock(1'b0);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+tb
hdl/mlsePkg.sv
hdl/acsOp.sv
hdl/acsStage.sv
hdl/setupDistributor.sv
hdl/metricDecision.sv
hdl/mlseDetector.sv
tb/mlseDetectorTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mlseDetectorTb -f list.f
./obj_dir/VmlseDetectorTb 2>&1 | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "simulation passed"
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi
